//--- sources.f
+incdir+dv
source/smartnic_app_pkg.sv
source/axi4s_intf.sv
source/axi4l_intf.sv
source/smartnic_app_regs.sv
source/smartnic_app_tagger.sv
source/smartnic_app.sv
dv/tb_smartnic_app.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_smartnic_app \
    --Mdir obj_dir \
    -o tb_smartnic_app \
    -f sources.f

./obj_dir/tb_smartnic_app | tee sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- dv/tb_smartnic_app_util.svh
`ifndef TB_SMARTNIC_APP_UTIL_SVH
`define TB_SMARTNIC_APP_UTIL_SVH

// ------------------------------------------------------------
// Random numbers
// ------------------------------------------------------------
// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v          = {v[30:0], fb};
    end
    return v;
endfunction

// ------------------------------------------------------------
// Reference model
// ------------------------------------------------------------
// Fold 12 bits at a time from the bottom, last slice is the top nibble
function automatic logic [11:0] entropy_model(input logic [63:0] d);
    logic [11:0] acc;
    logic [63:0] rest;
    acc  = '0;
    rest = d;
    for (int i = 0; i < 6; i++) begin
        acc  = acc ^ rest[11:0];
        rest = rest >> 12;
    end
    return acc;
endfunction

// Metadata of a packet from the settings at its first beat
function automatic tuser_smartnic_meta_t meta_model(input logic [15:0] pid,
                                                    input logic [1:0]  ctrl,
                                                    input logic [15:0] len,
                                                    input logic [63:0] first_data);
    tuser_smartnic_meta_t m;
    m.pid          = pid;
    m.trunc_enable = ctrl[0];
    m.trunc_length = ctrl[0] ? len : 16'h0000;
    m.rss_enable   = ctrl[1];
    m.rss_entropy  = ctrl[1] ? entropy_model(first_data) : 12'h000;
    return m;
endfunction

task automatic compare_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

// ------------------------------------------------------------
// AXI-Lite accesses
// ------------------------------------------------------------
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] resp);
    @(posedge core_clk);
    #1;
    axil_awvalid = 1'b1;
    axil_awaddr  = addr;
    axil_wvalid  = 1'b1;
    axil_wdata   = data;
    axil_wstrb   = strb;
    @(negedge core_clk);
    while (!(axil_awready && axil_wready)) begin
        @(negedge core_clk);
    end
    @(posedge core_clk);
    #1;
    axil_awvalid = 1'b0;
    axil_wvalid  = 1'b0;
    axil_bready  = 1'b1;
    @(negedge core_clk);
    while (!axil_bvalid) begin
        @(negedge core_clk);
    end
    resp = axil_bresp;
    @(posedge core_clk);
    #1;
    axil_bready = 1'b0;
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    @(posedge core_clk);
    #1;
    axil_arvalid = 1'b1;
    axil_araddr  = addr;
    @(negedge core_clk);
    while (!axil_arready) begin
        @(negedge core_clk);
    end
    @(posedge core_clk);
    #1;
    axil_arvalid = 1'b0;
    axil_rready  = 1'b1;
    @(negedge core_clk);
    while (!axil_rvalid) begin
        @(negedge core_clk);
    end
    data = axil_rdata;
    resp = axil_rresp;
    @(posedge core_clk);
    #1;
    axil_rready = 1'b0;
endtask

`endif

//--- dv/tb_smartnic_app.sv
`timescale 1ns/100ps

module tb_smartnic_app;
    import smartnic_app_pkg::*;

    localparam int NUM_PKTS       = 200;
    localparam int PHASES         = 4;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * 4 * 4 + 2000;

    typedef struct packed {
        logic [63:0]          data;
        logic [7:0]           keep;
        logic                 last;
        port_t                tid;
        port_t                tdest;
        tuser_smartnic_meta_t meta;
    } beat_t;

    logic core_clk;
    logic arst_n;

    // AXI-Lite
    logic        axil_awvalid;
    logic        axil_awready;
    logic [31:0] axil_awaddr;
    logic [2:0]  axil_awprot;
    logic        axil_wvalid;
    logic        axil_wready;
    logic [31:0] axil_wdata;
    logic [3:0]  axil_wstrb;
    logic        axil_bvalid;
    logic        axil_bready;
    logic [1:0]  axil_bresp;
    logic        axil_arvalid;
    logic        axil_arready;
    logic [31:0] axil_araddr;
    logic [2:0]  axil_arprot;
    logic        axil_rvalid;
    logic        axil_rready;
    logic [31:0] axil_rdata;
    logic [1:0]  axil_rresp;

    // Streams
    logic [NUM_PORTS-1:0]    axis_app_igr_tvalid;
    logic [NUM_PORTS-1:0]    axis_app_igr_tready;
    logic [NUM_PORTS*64-1:0] axis_app_igr_tdata;
    logic [NUM_PORTS*8-1:0]  axis_app_igr_tkeep;
    logic [NUM_PORTS-1:0]    axis_app_igr_tlast;
    logic [NUM_PORTS*4-1:0]  axis_app_igr_tid;
    logic [NUM_PORTS*4-1:0]  axis_app_igr_tdest;
    logic [NUM_PORTS*16-1:0] axis_app_igr_tuser_pid;
    logic [NUM_PORTS-1:0]    axis_app_egr_tvalid;
    logic [NUM_PORTS-1:0]    axis_app_egr_tready;
    logic [NUM_PORTS*64-1:0] axis_app_egr_tdata;
    logic [NUM_PORTS*8-1:0]  axis_app_egr_tkeep;
    logic [NUM_PORTS-1:0]    axis_app_egr_tlast;
    logic [NUM_PORTS*4-1:0]  axis_app_egr_tid;
    logic [NUM_PORTS*4-1:0]  axis_app_egr_tdest;
    logic [NUM_PORTS*16-1:0] axis_app_egr_tuser_pid;
    logic [NUM_PORTS-1:0]    axis_app_egr_tuser_trunc_enable;
    logic [NUM_PORTS*16-1:0] axis_app_egr_tuser_trunc_length;
    logic [NUM_PORTS-1:0]    axis_app_egr_tuser_rss_enable;
    logic [NUM_PORTS*12-1:0] axis_app_egr_tuser_rss_entropy;

    // Scoreboard and stimulus state
    int                   errors;
    int                   checks;
    int                   cycle_cnt = 0;
    logic [31:0]          lfsr_state;
    logic [1:0]           cur_ctrl;
    logic [15:0]          cur_len;
    logic [15:0]          next_pid;
    int                   pkts_sent [NUM_PORTS];
    int                   beats_left [NUM_PORTS];
    logic [15:0]          pkt_pid [NUM_PORTS];
    logic [NUM_PORTS-1:0] has_beat;
    logic [NUM_PORTS-1:0] igr_xfer;
    logic [NUM_PORTS-1:0] in_first;
    tuser_smartnic_meta_t cur_meta [NUM_PORTS];
    beat_t                exp_q [NUM_PORTS][$];

    `include "tb_smartnic_app_util.svh"

    smartnic_app UUT (.*);

    always #50 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Egress scoreboard
    // ------------------------------------------------------------
    task automatic check_egress(input int p);
        beat_t e;
        string sfx;
        sfx = $sformatf("[%0d]", p);
        if (exp_q[p].size() == 0) begin
            errors++;
            $display("Error at %0t ns: port %0d sent an egress beat with none expected",
                     $time, p);
        end else begin
            e = exp_q[p].pop_front();
            compare_field({"axis_app_egr_tdata", sfx}, axis_app_egr_tdata[p*64 +: 64], e.data);
            compare_field({"axis_app_egr_tkeep", sfx}, 64'(axis_app_egr_tkeep[p*8 +: 8]),
                          64'(e.keep));
            compare_field({"axis_app_egr_tlast", sfx}, 64'(axis_app_egr_tlast[p]), 64'(e.last));
            compare_field({"axis_app_egr_tid", sfx}, 64'(axis_app_egr_tid[p*4 +: 4]), 64'(e.tid));
            compare_field({"axis_app_egr_tdest", sfx}, 64'(axis_app_egr_tdest[p*4 +: 4]),
                          64'(e.tdest));
            compare_field({"axis_app_egr_tuser_pid", sfx},
                          64'(axis_app_egr_tuser_pid[p*16 +: 16]), 64'(e.meta.pid));
            compare_field({"axis_app_egr_tuser_trunc_enable", sfx},
                          64'(axis_app_egr_tuser_trunc_enable[p]), 64'(e.meta.trunc_enable));
            compare_field({"axis_app_egr_tuser_trunc_length", sfx},
                          64'(axis_app_egr_tuser_trunc_length[p*16 +: 16]),
                          64'(e.meta.trunc_length));
            compare_field({"axis_app_egr_tuser_rss_enable", sfx},
                          64'(axis_app_egr_tuser_rss_enable[p]), 64'(e.meta.rss_enable));
            compare_field({"axis_app_egr_tuser_rss_entropy", sfx},
                          64'(axis_app_egr_tuser_rss_entropy[p*12 +: 12]),
                          64'(e.meta.rss_entropy));
        end
    endtask

    // Random packets on both ports until npkts are sent and everything drained
    task automatic run_traffic(input int npkts);
        int    started;
        bit    busy;
        beat_t b;
        started = 0;
        busy    = 1'b1;
        while (busy) begin
            @(posedge core_clk);
            #1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (igr_xfer[p]) begin
                    has_beat[p] = 1'b0;
                end
                if (!has_beat[p] && beats_left[p] == 0 && started < npkts
                        && rand_bits(1) == 1) begin
                    beats_left[p] = 1 + int'(rand_bits(2));
                    pkt_pid[p]    = next_pid;
                    next_pid      = next_pid + 16'd1;
                    started++;
                    pkts_sent[p]++;
                end
                // Gap of random length before each beat
                if (!has_beat[p] && beats_left[p] > 0 && rand_bits(2) != 0) begin
                    beats_left[p]--;
                    axis_app_igr_tdata[p*64 +: 32]     = rand_bits(32);
                    axis_app_igr_tdata[p*64+32 +: 32]  = rand_bits(32);
                    axis_app_igr_tkeep[p*8 +: 8]       = 8'(rand_bits(8));
                    axis_app_igr_tlast[p]              = (beats_left[p] == 0);
                    axis_app_igr_tid[p*4 +: 4]         = 4'(p);
                    axis_app_igr_tdest[p*4 +: 4]       = 4'(rand_bits(4));
                    axis_app_igr_tuser_pid[p*16 +: 16] = pkt_pid[p];
                    has_beat[p] = 1'b1;
                end
                axis_app_igr_tvalid[p] = has_beat[p];
                axis_app_egr_tready[p] = (rand_bits(2) != 0);
            end

            @(negedge core_clk);
            busy = (started < npkts);
            for (int p = 0; p < NUM_PORTS; p++) begin
                igr_xfer[p] = axis_app_igr_tvalid[p] && axis_app_igr_tready[p];
                if (igr_xfer[p]) begin
                    b.data  = axis_app_igr_tdata[p*64 +: 64];
                    b.keep  = axis_app_igr_tkeep[p*8 +: 8];
                    b.last  = axis_app_igr_tlast[p];
                    b.tid   = axis_app_igr_tid[p*4 +: 4];
                    b.tdest = axis_app_igr_tdest[p*4 +: 4];
                    if (in_first[p]) begin
                        cur_meta[p] = meta_model(16'h0000, cur_ctrl, cur_len, b.data);
                    end
                    b.meta     = cur_meta[p];
                    b.meta.pid = axis_app_igr_tuser_pid[p*16 +: 16];
                    exp_q[p].push_back(b);
                    in_first[p] = b.last;
                end
                if (axis_app_egr_tvalid[p] && axis_app_egr_tready[p]) begin
                    check_egress(p);
                end
                if ((has_beat[p] && !igr_xfer[p]) || beats_left[p] > 0
                        || exp_q[p].size() > 0 || axis_app_egr_tvalid[p]) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [1:0]  resp;
        logic [31:0] rdata;
        logic [15:0] len;
        core_clk     = 1'b0;
        arst_n       = 1'b0;
        lfsr_state   = 32'ha15b2194;
        errors       = 0;
        checks       = 0;
        next_pid     = 16'd0;
        axil_awvalid = 1'b0;
        axil_awaddr  = '0;
        axil_awprot  = '0;
        axil_wvalid  = 1'b0;
        axil_wdata   = '0;
        axil_wstrb   = '0;
        axil_bready  = 1'b0;
        axil_arvalid = 1'b0;
        axil_araddr  = '0;
        axil_arprot  = '0;
        axil_rready  = 1'b0;
        axis_app_igr_tvalid    = '0;
        axis_app_igr_tdata     = '0;
        axis_app_igr_tkeep     = '0;
        axis_app_igr_tlast     = '0;
        axis_app_igr_tid       = '0;
        axis_app_igr_tdest     = '0;
        axis_app_igr_tuser_pid = '0;
        axis_app_egr_tready    = '1;
        has_beat = '0;
        igr_xfer = '0;
        in_first = '1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            pkts_sent[p]  = 0;
            beats_left[p] = 0;
        end
        repeat (8) @(posedge core_clk);
        #1;
        arst_n = 1'b1;

        // Every combination of the two enables gets a quarter of the packets
        for (int ph = 0; ph < PHASES; ph++) begin
            len = 16'(rand_bits(16));
            axil_write(REG_TRUNC_LEN, {16'h0000, len}, 4'b0011, resp);
            compare_field("axil_bresp", 64'(resp), 64'(RESP_OKAY));
            axil_write(REG_CTRL, 32'(ph), 4'b0001, resp);
            compare_field("axil_bresp", 64'(resp), 64'(RESP_OKAY));
            cur_ctrl = 2'(ph);
            cur_len  = len;
            run_traffic(NUM_PKTS / PHASES);
        end

        for (int p = 0; p < NUM_PORTS; p++) begin
            axil_read((p == 0) ? REG_PKT_CNT0 : REG_PKT_CNT1, rdata, resp);
            compare_field($sformatf("axil_rdata pkt_cnt[%0d]", p), 64'(rdata), 64'(pkts_sent[p]));
            compare_field("axil_rresp", 64'(resp), 64'(RESP_OKAY));
        end

        // Both lanes carry inverted data and only lane 1 is enabled
        axil_write(REG_TRUNC_LEN, {16'h1234, ~cur_len}, 4'b0010, resp);
        compare_field("axil_bresp", 64'(resp), 64'(RESP_OKAY));
        cur_len = {~cur_len[15:8], cur_len[7:0]};
        axil_read(REG_TRUNC_LEN, rdata, resp);
        compare_field("axil_rdata trunc_len", 64'(rdata), 64'({16'h0000, cur_len}));
        compare_field("axil_rresp", 64'(resp), 64'(RESP_OKAY));
        axil_read(REG_CTRL, rdata, resp);
        compare_field("axil_rdata ctrl", 64'(rdata), 64'({30'd0, cur_ctrl}));
        compare_field("axil_rresp", 64'(resp), 64'(RESP_OKAY));

        // Unmapped address
        axil_write(32'h0000_0010, 32'hffff_ffff, 4'b1111, resp);
        compare_field("axil_bresp unmapped", 64'(resp), 64'(RESP_SLVERR));
        axil_read(32'h0000_0010, rdata, resp);
        compare_field("axil_rresp unmapped", 64'(resp), 64'(RESP_SLVERR));
        compare_field("axil_rdata unmapped", 64'(rdata), 64'd0);

        $display("Checks: %0d, errors: %0d, packets: %0d", checks, errors, next_pid);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- source/smartnic_app.sv
`timescale 1ns/100ps

module smartnic_app (
    input  logic         core_clk,
    input  logic         arst_n,

    // AXI-Lite control, write side
    input  logic         axil_awvalid,
    output logic         axil_awready,
    input  logic [31:0]  axil_awaddr,
    input  logic [2:0]   axil_awprot,
    input  logic         axil_wvalid,
    output logic         axil_wready,
    input  logic [31:0]  axil_wdata,
    input  logic [3:0]   axil_wstrb,
    output logic         axil_bvalid,
    input  logic         axil_bready,
    output logic [1:0]   axil_bresp,
    // Read side
    input  logic         axil_arvalid,
    output logic         axil_arready,
    input  logic [31:0]  axil_araddr,
    input  logic [2:0]   axil_arprot,
    output logic         axil_rvalid,
    input  logic         axil_rready,
    output logic [31:0]  axil_rdata,
    output logic [1:0]   axil_rresp,

    // Ingress streams
    input  logic [(smartnic_app_pkg::NUM_PORTS* 1)-1:0] axis_app_igr_tvalid,
    output logic [(smartnic_app_pkg::NUM_PORTS* 1)-1:0] axis_app_igr_tready,
    input  logic [(smartnic_app_pkg::NUM_PORTS*64)-1:0] axis_app_igr_tdata,
    input  logic [(smartnic_app_pkg::NUM_PORTS* 8)-1:0] axis_app_igr_tkeep,
    input  logic [(smartnic_app_pkg::NUM_PORTS* 1)-1:0] axis_app_igr_tlast,
    input  logic [(smartnic_app_pkg::NUM_PORTS* 4)-1:0] axis_app_igr_tid,
    input  logic [(smartnic_app_pkg::NUM_PORTS* 4)-1:0] axis_app_igr_tdest,
    input  logic [(smartnic_app_pkg::NUM_PORTS*16)-1:0] axis_app_igr_tuser_pid,

    // Egress streams
    output logic [(smartnic_app_pkg::NUM_PORTS* 1)-1:0] axis_app_egr_tvalid,
    input  logic [(smartnic_app_pkg::NUM_PORTS* 1)-1:0] axis_app_egr_tready,
    output logic [(smartnic_app_pkg::NUM_PORTS*64)-1:0] axis_app_egr_tdata,
    output logic [(smartnic_app_pkg::NUM_PORTS* 8)-1:0] axis_app_egr_tkeep,
    output logic [(smartnic_app_pkg::NUM_PORTS* 1)-1:0] axis_app_egr_tlast,
    output logic [(smartnic_app_pkg::NUM_PORTS* 4)-1:0] axis_app_egr_tid,
    output logic [(smartnic_app_pkg::NUM_PORTS* 4)-1:0] axis_app_egr_tdest,
    output logic [(smartnic_app_pkg::NUM_PORTS*16)-1:0] axis_app_egr_tuser_pid,
    output logic [(smartnic_app_pkg::NUM_PORTS* 1)-1:0] axis_app_egr_tuser_trunc_enable,
    output logic [(smartnic_app_pkg::NUM_PORTS*16)-1:0] axis_app_egr_tuser_trunc_length,
    output logic [(smartnic_app_pkg::NUM_PORTS* 1)-1:0] axis_app_egr_tuser_rss_enable,
    output logic [(smartnic_app_pkg::NUM_PORTS*12)-1:0] axis_app_egr_tuser_rss_entropy
);
    import smartnic_app_pkg::*;

    axi4l_intf axil_if ();

    axi4s_intf #(.TID_T(port_t), .TDEST_T(port_t), .TUSER_T(tuser_igr_t))
        axis_app_igr [NUM_PORTS] ();
    axi4s_intf #(.TID_T(port_t), .TDEST_T(port_t), .TUSER_T(tuser_smartnic_meta_t))
        axis_app_egr [NUM_PORTS] ();

    app_cfg_t             cfg;
    logic [NUM_PORTS-1:0] pkt_done;

    // ------------------------------------------------------------
    // Flat AXI-Lite ports onto the controller side
    // ------------------------------------------------------------
    assign axil_if.awvalid = axil_awvalid;
    assign axil_if.awaddr  = axil_awaddr;
    assign axil_if.awprot  = axil_awprot;
    assign axil_if.wvalid  = axil_wvalid;
    assign axil_if.wdata   = axil_wdata;
    assign axil_if.wstrb   = axil_wstrb;
    assign axil_if.bready  = axil_bready;
    assign axil_if.arvalid = axil_arvalid;
    assign axil_if.araddr  = axil_araddr;
    assign axil_if.arprot  = axil_arprot;
    assign axil_if.rready  = axil_rready;
    assign axil_awready    = axil_if.awready;
    assign axil_wready     = axil_if.wready;
    assign axil_bvalid     = axil_if.bvalid;
    assign axil_bresp      = axil_if.bresp;
    assign axil_arready    = axil_if.arready;
    assign axil_rvalid     = axil_if.rvalid;
    assign axil_rdata      = axil_if.rdata;
    assign axil_rresp      = axil_if.rresp;

    smartnic_app_regs regs (
        .core_clk ( core_clk ),
        .arst_n   ( arst_n ),
        .axil     ( axil_if ),
        .cfg      ( cfg ),
        .pkt_done ( pkt_done )
    );

    // ------------------------------------------------------------
    // Per-port stream slicing and taggers
    // ------------------------------------------------------------
    generate
        for (genvar j = 0; j < NUM_PORTS; j++) begin : g_port
            assign axis_app_igr[j].tvalid    = axis_app_igr_tvalid[j];
            assign axis_app_igr[j].tdata     = axis_app_igr_tdata[j*DATA_WID +: DATA_WID];
            assign axis_app_igr[j].tkeep     = axis_app_igr_tkeep[j*DATA_BYTE_WID +: DATA_BYTE_WID];
            assign axis_app_igr[j].tlast     = axis_app_igr_tlast[j];
            assign axis_app_igr[j].tid       = axis_app_igr_tid[j*4 +: 4];
            assign axis_app_igr[j].tdest     = axis_app_igr_tdest[j*4 +: 4];
            assign axis_app_igr[j].tuser.pid = axis_app_igr_tuser_pid[j*16 +: 16];
            assign axis_app_igr_tready[j]    = axis_app_igr[j].tready;

            assign axis_app_egr[j].tready    = axis_app_egr_tready[j];
            assign axis_app_egr_tvalid[j]    = axis_app_egr[j].tvalid;
            assign axis_app_egr_tdata[j*DATA_WID +: DATA_WID] = axis_app_egr[j].tdata;
            assign axis_app_egr_tkeep[j*DATA_BYTE_WID +: DATA_BYTE_WID] = axis_app_egr[j].tkeep;
            assign axis_app_egr_tlast[j]     = axis_app_egr[j].tlast;
            assign axis_app_egr_tid[j*4 +: 4]   = axis_app_egr[j].tid;
            assign axis_app_egr_tdest[j*4 +: 4] = axis_app_egr[j].tdest;
            assign axis_app_egr_tuser_pid[j*16 +: 16] = axis_app_egr[j].tuser.pid;
            assign axis_app_egr_tuser_trunc_enable[j] = axis_app_egr[j].tuser.trunc_enable;
            assign axis_app_egr_tuser_trunc_length[j*16 +: 16] = axis_app_egr[j].tuser.trunc_length;
            assign axis_app_egr_tuser_rss_enable[j] = axis_app_egr[j].tuser.rss_enable;
            assign axis_app_egr_tuser_rss_entropy[j*12 +: 12] = axis_app_egr[j].tuser.rss_entropy;

            smartnic_app_tagger tagger (
                .core_clk ( core_clk ),
                .arst_n   ( arst_n ),
                .cfg      ( cfg ),
                .axis_in  ( axis_app_igr[j] ),
                .axis_out ( axis_app_egr[j] ),
                .pkt_done ( pkt_done[j] )
            );
        end
    endgenerate

endmodule

//--- source/smartnic_app_tagger.sv
`timescale 1ns/100ps

module smartnic_app_tagger (
    input  logic                       core_clk,
    input  logic                       arst_n,
    input  smartnic_app_pkg::app_cfg_t cfg,
    axi4s_intf.rx                      axis_in,
    axi4s_intf.tx                      axis_out,
    output logic                       pkt_done
);
    import smartnic_app_pkg::*;

    // XOR of 12-bit slices, top nibble zero extended
    function automatic logic [11:0] rss_fold(input logic [DATA_WID-1:0] d);
        return d[11:0] ^ d[23:12] ^ d[35:24] ^ d[47:36] ^ d[59:48] ^ {8'h00, d[63:60]};
    endfunction

    logic                     in_xfer;
    logic                     out_xfer;
    logic                     first_q;
    logic                     out_valid_q;

    // Output beat
    logic [DATA_WID-1:0]      tdata_q;
    logic [DATA_BYTE_WID-1:0] tkeep_q;
    logic                     tlast_q;
    port_t                    tid_q;
    port_t                    tdest_q;
    logic [15:0]              pid_q;

    // Metadata captured once per packet
    logic                     trunc_enable_q;
    logic [15:0]              trunc_length_q;
    logic                     rss_enable_q;
    logic [11:0]              rss_entropy_q;

    tuser_smartnic_meta_t     tuser_out;

    // ------------------------------------------------------------
    // Flow control
    // ------------------------------------------------------------
    // Accept when the stage is empty or draining this cycle
    assign out_xfer       = out_valid_q && axis_out.tready;
    assign axis_in.tready = !out_valid_q || axis_out.tready;
    assign in_xfer        = axis_in.tvalid && axis_in.tready;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= 1'b0;
            first_q     <= 1'b1;
        end else begin
            if (in_xfer) begin
                out_valid_q <= 1'b1;
                first_q     <= axis_in.tlast;
            end else if (out_xfer) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Payload and metadata
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (in_xfer) begin
            tdata_q <= axis_in.tdata;
            tkeep_q <= axis_in.tkeep;
            tlast_q <= axis_in.tlast;
            tid_q   <= axis_in.tid;
            tdest_q <= axis_in.tdest;
            pid_q   <= axis_in.tuser.pid;
            // New packet enters the stage together with its metadata
            if (first_q) begin
                trunc_enable_q <= cfg.trunc_enable;
                trunc_length_q <= cfg.trunc_enable ? cfg.trunc_length : 16'h0000;
                rss_enable_q   <= cfg.rss_enable;
                rss_entropy_q  <= cfg.rss_enable ? rss_fold(axis_in.tdata) : 12'h000;
            end
        end
    end

    always_comb begin
        tuser_out.pid          = pid_q;
        tuser_out.trunc_enable = trunc_enable_q;
        tuser_out.trunc_length = trunc_length_q;
        tuser_out.rss_enable   = rss_enable_q;
        tuser_out.rss_entropy  = rss_entropy_q;
    end

    assign axis_out.tvalid = out_valid_q;
    assign axis_out.tdata  = tdata_q;
    assign axis_out.tkeep  = tkeep_q;
    assign axis_out.tlast  = tlast_q;
    assign axis_out.tid    = tid_q;
    assign axis_out.tdest  = tdest_q;
    assign axis_out.tuser  = tuser_out;

    // One pulse per packet leaving the port
    assign pkt_done = out_xfer && tlast_q;

endmodule

//--- source/smartnic_app_regs.sv
`timescale 1ns/100ps

module smartnic_app_regs (
    input  logic                                   core_clk,
    input  logic                                   arst_n,
    axi4l_intf.peripheral                          axil,
    output smartnic_app_pkg::app_cfg_t             cfg,
    input  logic [smartnic_app_pkg::NUM_PORTS-1:0] pkt_done
);
    import smartnic_app_pkg::*;

    app_cfg_t                 cfg_q;
    logic [AXIL_DATA_WID-1:0] pkt_cnt [NUM_PORTS];

    logic                     wr_go;
    logic                     rd_go;
    logic                     wr_hit;
    logic                     rd_hit;
    logic [AXIL_DATA_WID-1:0] rd_data;

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------
    // AW and W are taken together, one access in flight per direction
    assign wr_go        = axil.awvalid && axil.wvalid && !axil.bvalid;
    assign rd_go        = axil.arvalid && !axil.rvalid;
    assign axil.awready = wr_go;
    assign axil.wready  = wr_go;
    assign axil.arready = rd_go;

    // Counters accept writes silently
    always_comb begin
        case (axil.awaddr)
            REG_CTRL, REG_TRUNC_LEN, REG_PKT_CNT0, REG_PKT_CNT1: wr_hit = 1'b1;
            default: wr_hit = 1'b0;
        endcase
    end

    // Read mux, unmapped reads return zero
    always_comb begin
        rd_hit  = 1'b1;
        rd_data = '0;
        case (axil.araddr)
            REG_CTRL: begin
                rd_data[0] = cfg_q.trunc_enable;
                rd_data[1] = cfg_q.rss_enable;
            end
            REG_TRUNC_LEN: rd_data[15:0] = cfg_q.trunc_length;
            REG_PKT_CNT0:  rd_data = pkt_cnt[0];
            REG_PKT_CNT1:  rd_data = pkt_cnt[1];
            default:       rd_hit = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_q <= '0;
        end else if (wr_go) begin
            case (axil.awaddr)
                REG_CTRL: begin
                    if (axil.wstrb[0]) begin
                        cfg_q.trunc_enable <= axil.wdata[0];
                        cfg_q.rss_enable   <= axil.wdata[1];
                    end
                end
                REG_TRUNC_LEN: begin
                    // Byte lanes 0 and 1 only
                    if (axil.wstrb[0]) begin
                        cfg_q.trunc_length[7:0] <= axil.wdata[7:0];
                    end
                    if (axil.wstrb[1]) begin
                        cfg_q.trunc_length[15:8] <= axil.wdata[15:8];
                    end
                end
                default: ;
            endcase
        end
    end

    assign cfg = cfg_q;

    // Packet counters, free running and wrapping
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                pkt_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (pkt_done[p]) begin
                    pkt_cnt[p] <= pkt_cnt[p] + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Response channels
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            axil.bvalid <= 1'b0;
            axil.rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                axil.bvalid <= 1'b1;
            end else if (axil.bready) begin
                axil.bvalid <= 1'b0;
            end
            if (rd_go) begin
                axil.rvalid <= 1'b1;
            end else if (axil.rready) begin
                axil.rvalid <= 1'b0;
            end
        end
    end

    // Held stable while the valid above waits for ready
    always_ff @(posedge core_clk) begin
        if (wr_go) begin
            axil.bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_go) begin
            axil.rdata <= rd_data;
            axil.rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- source/axi4l_intf.sv
`timescale 1ns/100ps

interface axi4l_intf ();
    import smartnic_app_pkg::*;

    logic                       awvalid, awready;
    logic [AXIL_ADDR_WID-1:0]   awaddr;
    logic [2:0]                 awprot;
    logic                       wvalid, wready;
    logic [AXIL_DATA_WID-1:0]   wdata;
    logic [AXIL_DATA_WID/8-1:0] wstrb;
    logic                       bvalid, bready;
    logic [1:0]                 bresp;
    logic                       arvalid, arready;
    logic [AXIL_ADDR_WID-1:0]   araddr;
    logic [2:0]                 arprot;
    logic                       rvalid, rready;
    logic [AXIL_DATA_WID-1:0]   rdata;
    logic [1:0]                 rresp;

    modport controller (
        output awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, arprot, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport peripheral (
        input  awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, arprot, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

//--- source/axi4s_intf.sv
`timescale 1ns/100ps

interface axi4s_intf #(
    parameter type TID_T   = smartnic_app_pkg::port_t,
    parameter type TDEST_T = smartnic_app_pkg::port_t,
    parameter type TUSER_T = smartnic_app_pkg::tuser_igr_t
) ();
    import smartnic_app_pkg::*;

    logic                     tvalid;
    logic                     tready;
    logic [DATA_WID-1:0]      tdata;
    logic [DATA_BYTE_WID-1:0] tkeep;
    logic                     tlast;
    TID_T                     tid;
    TDEST_T                   tdest;
    TUSER_T                   tuser;

    // Sender side
    modport tx (
        output tvalid, tdata, tkeep, tlast, tid, tdest, tuser,
        input  tready
    );

    // Receiver side, only back-pressure goes upstream
    modport rx (
        input  tvalid, tdata, tkeep, tlast, tid, tdest, tuser,
        output tready
    );

endinterface

//--- source/smartnic_app_pkg.sv
package smartnic_app_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int NUM_PORTS     = 2;
    localparam int DATA_BYTE_WID = 8;
    localparam int DATA_WID      = DATA_BYTE_WID * 8;
    localparam int AXIL_ADDR_WID = 32;
    localparam int AXIL_DATA_WID = 32;

    typedef logic [3:0] port_t;

    // Ingress user field, packet id only
    typedef struct packed {
        logic [15:0] pid;
    } tuser_igr_t;

    // Egress user field as seen by the downstream pipeline
    typedef struct packed {
        logic [15:0] pid;
        logic        trunc_enable;
        logic [15:0] trunc_length;
        logic        rss_enable;
        logic [11:0] rss_entropy;
    } tuser_smartnic_meta_t;

    // Settings from the register block to each tagger
    typedef struct packed {
        logic        trunc_enable;
        logic        rss_enable;
        logic [15:0] trunc_length;
    } app_cfg_t;

    // ------------------------------------------------------------
    // Register map and responses
    // ------------------------------------------------------------
    localparam logic [AXIL_ADDR_WID-1:0] REG_CTRL      = 'h00;
    localparam logic [AXIL_ADDR_WID-1:0] REG_TRUNC_LEN = 'h04;
    localparam logic [AXIL_ADDR_WID-1:0] REG_PKT_CNT0  = 'h08;
    localparam logic [AXIL_ADDR_WID-1:0] REG_PKT_CNT1  = 'h0C;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

endpackage
